/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

    // R-type layout, used here for OP and the M extension
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_type_t;

    // J-type layout with the immediate bits as they sit in the word
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_j_type_t;

    // one fetched word, read through either format
    typedef union packed {
        logic [31:0] raw;
        rv_r_type_t  r;
        rv_j_type_t  j;
    } rv_inst_u;

    localparam logic [6:0] OPC_JAL = 7'b110_1111;
    localparam logic [6:0] OPC_OP  = 7'b011_0011;

    localparam logic [6:0] F7_MULDIV = 7'b000_0001;  // M extension

    // cycles the decoder stays busy per unit
    localparam logic [3:0] MUL_LAT = 4'd3;
    localparam logic [3:0] DIV_LAT = 4'd8;

endpackage

/* verilog/fetch_pkg.sv */
package fetch_pkg;

    localparam logic [31:0] RESET_PC = 32'h8000_0000;

    // queue sizing, pointer width must cover the depth exactly
    localparam int QDEPTH = 4;
    localparam int QPTR_W = 2;

    // one queue slot, also the retire payload
    typedef struct packed {
        logic [31:0]          pc;
        rv_isa_pkg::rv_inst_u inst;
    } fetch_entry_t;

    // flow change from decode back to fetch
    typedef struct packed {
        logic        valid;   // single cycle
        logic [31:0] target;
    } redirect_t;

endpackage

/* verilog/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    full,
    input  fetch_pkg::redirect_t    redirect,
    input  logic                    mem_done,
    input  logic [31:0]             mem_rdata,
    output logic                    mem_req,
    output logic [31:0]             mem_addr,
    output logic                    push,
    output fetch_pkg::fetch_entry_t push_entry
);
    import fetch_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_WAIT
    } state_t;

    state_t      state;
    logic [31:0] pc;        // address of the next or outstanding fetch
    logic        stale;     // outstanding response belongs to a dead path
    logic        issue;
    logic [31:0] fetch_pc;

    // a redirect seen in IDLE goes straight out as the next address
    assign fetch_pc = redirect.valid ? redirect.target : pc;

    // queue is flushed by the redirect, so full does not block it
    assign issue = (state == ST_IDLE) && (!full || redirect.valid);

    // drop the response when the path just changed under it
    assign push = (state == ST_WAIT) && mem_done && !stale && !redirect.valid;

    assign mem_addr = pc;

    assign push_entry.pc       = pc;
    assign push_entry.inst.raw = mem_rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            pc      <= RESET_PC;
            stale   <= 1'b0;
            mem_req <= 1'b0;
        end else begin
            mem_req <= issue;  // pulse in the first WAIT cycle
            case (state)
                ST_IDLE: begin
                    pc <= fetch_pc;
                    if (issue) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (mem_done) begin
                        state <= ST_IDLE;
                        stale <= 1'b0;
                        if (redirect.valid) begin
                            pc <= redirect.target;
                        end else if (!stale) begin
                            pc <= pc + 32'd4;
                        end
                    end else if (redirect.valid) begin
                        // request still in flight, its answer gets dropped
                        pc    <= redirect.target;
                        stale <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* verilog/inst_queue.sv */
`timescale 1ns/1ps

module inst_queue (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push,
    input  fetch_pkg::fetch_entry_t push_entry,
    input  logic                    pop,
    input  logic                    flush,
    output fetch_pkg::fetch_entry_t head,
    output logic                    empty,
    output logic                    full
);
    import fetch_pkg::*;

    fetch_entry_t      entries [QDEPTH];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QPTR_W:0]   count;

    assign head  = entries[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == (QPTR_W + 1)'(QDEPTH));

    // entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            // wins over a push at the same edge
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verilog/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fetch_pkg::fetch_entry_t head,
    input  logic                    empty,
    output logic                    pop,
    output fetch_pkg::redirect_t    redirect,
    output logic                    retire_valid,
    output fetch_pkg::fetch_entry_t retire
);
    import rv_isa_pkg::*;

    rv_inst_u    word;
    logic        is_muldiv;
    logic        is_div;
    logic        is_jal;
    logic [31:0] jal_off;
    logic [3:0]  unit_lat;
    logic [3:0]  busy_cnt;   // cycles left before the M result retires
    logic        busy;

    assign word = head.inst;

    // R-type view for the M extension
    assign is_muldiv = (word.r.opcode == OPC_OP) && (word.r.funct7 == F7_MULDIV);
    assign is_div    = word.r.funct3[2];
    assign unit_lat  = is_div ? DIV_LAT : MUL_LAT;

    // J-type view of the same word
    assign is_jal  = (word.j.opcode == OPC_JAL);
    assign jal_off = {{11{word.j.imm20}}, word.j.imm20, word.j.imm19_12,
                      word.j.imm11, word.j.imm10_1, 1'b0};

    assign busy = (busy_cnt != 4'd0);
    assign pop  = !empty && !busy;

    // rises with the pop of the JAL, doubles as queue flush
    assign redirect.valid  = pop && is_jal;
    assign redirect.target = head.pc + jal_off;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_cnt     <= 4'd0;
            retire_valid <= 1'b0;
        end else begin
            if (pop && is_muldiv) begin
                busy_cnt <= unit_lat - 4'd1;
            end else if (busy) begin
                busy_cnt <= busy_cnt - 4'd1;
            end
            // plain words retire next cycle, M ops when the count runs out
            retire_valid <= (pop && !is_muldiv) || (busy_cnt == 4'd1);
        end
    end

    // payload held through the busy window
    always_ff @(posedge clk) begin
        if (pop) begin
            retire <= head;
        end
    end

endmodule

/* verilog/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    mem_req,
    output logic [31:0]             mem_addr,
    input  logic                    mem_done,
    input  logic [31:0]             mem_rdata,
    output logic                    retire_valid,
    output fetch_pkg::fetch_entry_t retire
);
    import fetch_pkg::*;

    logic         full;
    logic         empty;
    logic         push;
    logic         pop;
    fetch_entry_t push_entry;
    fetch_entry_t head;
    redirect_t    redirect;

    pc_gen u_pc_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .full       (full),
        .redirect   (redirect),
        .mem_done   (mem_done),
        .mem_rdata  (mem_rdata),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .push       (push),
        .push_entry (push_entry)
    );

    inst_queue u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_entry (push_entry),
        .pop        (pop),
        .flush      (redirect.valid),   // a taken jump empties the queue
        .head       (head),
        .empty      (empty),
        .full       (full)
    );

    inst_decode u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .head         (head),
        .empty        (empty),
        .pop          (pop),
        .redirect     (redirect),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

/* tests/fetch_chk.sv */
`timescale 1ns/1ps

module fetch_chk (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    mem_req,
    input logic                    mem_done,
    input logic                    push,
    input logic                    full,
    input logic                    retire_valid,
    input fetch_pkg::fetch_entry_t retire
);
    logic outstanding;  // request sent, answer not back yet

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (mem_req) begin
            outstanding <= 1'b1;
        end else if (mem_done) begin
            outstanding <= 1'b0;
        end
    end

    a_one_req: assert property (@(posedge clk) disable iff (!rst_n) mem_req |-> !outstanding)
        else $error("mem_req issued while a request is outstanding");

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
        else $error("push into a full instruction queue");

    // word fetch only, so pc stays aligned
    a_pc_align: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> (retire.pc[1:0] == 2'b00))
        else $error("retired pc not 4-byte aligned");

endmodule

bind fetch_top fetch_chk u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_req      (mem_req),
    .mem_done     (mem_done),
    .push         (push),
    .full         (full),
    .retire_valid (retire_valid),
    .retire       (retire)
);

/* tests/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;
    import rv_isa_pkg::*;
    import fetch_pkg::*;

    localparam int PROG_LEN = 32;
    localparam int N_TESTS  = 4;

    logic         clk;
    logic         rst_n;
    logic         mem_req;
    logic [31:0]  mem_addr;
    logic         mem_done;
    logic [31:0]  mem_rdata;
    logic         retire_valid;
    fetch_entry_t retire;

    logic [31:0] prog [PROG_LEN];
    string       test_name [N_TESTS];
    int          test_start [N_TESTS];
    int          test_count [N_TESTS];

    logic [31:0] exp_pc [$];    // reference trace of the current test
    logic [31:0] exp_inst [$];

    integer      seed = 32'h563a_4874;
    int          cycle_limit = 0;
    int          wd_cycles = 0;
    int          now = 0;
    int          last_ret;
    int          n_ret;
    int          checks = 0;
    int          errors = 0;
    int          test_err;
    int          cur_start;
    logic        checking = 1'b0;

    // memory model state
    logic        pending = 1'b0;
    int          wait_left;
    logic [31:0] req_addr;

    fetch_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_done     (mem_done),
        .mem_rdata    (mem_rdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        wd_cycles <= wd_cycles + 1;
        if (wd_cycles >= cycle_limit) begin
            $display("timeout: tests did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i, 5'd0, 3'b000, rd, 7'b001_0011};
    endfunction

    function automatic logic [31:0] muldiv_word(input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic div);
        return {7'b000_0001, rs2, rs1, (div ? 3'b100 : 3'b000), rd, 7'b011_0011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], rd, 7'b110_1111};
    endfunction

    function automatic logic [31:0] jal_offset(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic logic is_muldiv(input logic [31:0] w);
        return (w[6:0] == 7'b011_0011) && (w[31:25] == 7'b000_0001);
    endfunction

    // test program sits at RESET_PC
    // anything outside reads as addi x0 with an address-derived immediate
    function automatic logic [31:0] mem_word(input logic [31:0] addr, input int start);
        int          idx;
        logic [11:0] fill;
        fill = addr[11:0] ^ addr[23:12] ^ {4'h0, addr[31:24]};
        if (addr < RESET_PC) begin
            return addi_word(5'd0, int'(fill));
        end
        idx = int'((addr - RESET_PC) >> 2);
        if (idx >= PROG_LEN - start) begin
            return addi_word(5'd0, int'(fill));
        end
        return prog[start + idx];
    endfunction

    task automatic load_program();
        int i;
        for (i = 0; i < 8; i++) begin
            prog[i] = addi_word(5'(i + 1), 16 * i + 1);  // straight line
        end
        prog[8]  = addi_word(5'd2, 5);
        prog[9]  = jal_word(5'd1, 12);     // forward, skips two
        prog[10] = addi_word(5'd3, 6);
        prog[11] = addi_word(5'd4, 7);
        prog[12] = addi_word(5'd5, 8);
        prog[13] = jal_word(5'd0, -20);    // back to the start
        prog[14] = addi_word(5'd6, 7);
        prog[15] = muldiv_word(5'd7, 5'd6, 5'd6, 1'b0);
        prog[16] = muldiv_word(5'd8, 5'd7, 5'd6, 1'b1);
        prog[17] = addi_word(5'd9, 9);
        prog[18] = muldiv_word(5'd10, 5'd9, 5'd8, 1'b0);
        prog[19] = addi_word(5'd11, 11);
        for (i = 20; i < 23; i++) begin
            prog[i] = muldiv_word(5'(i - 19), 5'd2, 5'd3, 1'b1);
        end
        for (i = 23; i < 28; i++) begin
            prog[i] = addi_word(5'(i - 12), i);
        end
        prog[28] = muldiv_word(5'd20, 5'd21, 5'd22, 1'b1);
        prog[29] = jal_word(5'd0, 8);
        prog[30] = addi_word(5'd23, 30);
        prog[31] = addi_word(5'd24, 31);
    endtask

    task automatic load_tests();
        test_name[0] = "straight";   test_start[0] = 0;   test_count[0] = 8;
        test_name[1] = "jal_loop";   test_start[1] = 8;   test_count[1] = 10;
        test_name[2] = "mul_div";    test_start[2] = 14;  test_count[2] = 6;
        test_name[3] = "div_stall";  test_start[3] = 20;  test_count[3] = 12;
    endtask

    // in-order walk of the program, following JAL targets
    task automatic build_trace(input int start, input int count);
        logic [31:0] pc;
        logic [31:0] w;
        int          n;
        exp_pc.delete();
        exp_inst.delete();
        pc = RESET_PC;
        for (n = 0; n < count; n++) begin
            w = mem_word(pc, start);
            exp_pc.push_back(pc);
            exp_inst.push_back(w);
            if (w[6:0] == 7'b110_1111) begin
                pc = pc + jal_offset(w);
            end else begin
                pc = pc + 32'd4;
            end
        end
    endtask

    task automatic check_retire();
        int lat;
        if (retire_valid && n_ret < exp_pc.size()) begin
            checks++;
            assert (retire.pc == exp_pc[n_ret]) else begin
                $display("error: %0t retire.pc expected %h actual %h",
                         $time, exp_pc[n_ret], retire.pc);
                test_err++;
            end
            assert (retire.inst.raw == exp_inst[n_ret]) else begin
                $display("error: %0t retire.inst expected %h actual %h",
                         $time, exp_inst[n_ret], retire.inst.raw);
                test_err++;
            end
            if (is_muldiv(exp_inst[n_ret])) begin
                lat = exp_inst[n_ret][14] ? int'(DIV_LAT) : int'(MUL_LAT);
                assert (now - last_ret >= lat) else begin
                    $display("error: %0t retire_valid gap expected >= %0d actual %0d",
                             $time, lat, now - last_ret);
                    test_err++;
                end
            end
            last_ret = now;
            n_ret++;
        end
    endtask

    // one cycle: memory model and monitor, all at the falling edge
    task automatic step_cycle();
        logic [31:0] rnd;
        @(negedge clk);
        now++;
        mem_done = 1'b0;
        if (!rst_n) begin
            pending = 1'b0;
        end else begin
            if (pending) begin
                if (wait_left == 1) begin
                    mem_done  = 1'b1;
                    mem_rdata = mem_word(req_addr, cur_start);
                    pending   = 1'b0;
                end else begin
                    wait_left--;
                end
            end
            if (mem_req) begin
                rnd       = $random(seed);
                wait_left = 1 + int'(rnd[1:0]);  // 1 to 4 cycles
                req_addr  = mem_addr;
                pending   = 1'b1;
            end
            if (checking) begin
                check_retire();
            end
        end
    endtask

    task automatic apply_reset();
        int i;
        checking = 1'b0;
        rst_n    = 1'b0;
        for (i = 0; i < 4; i++) begin
            step_cycle();
            checks++;
            assert (!mem_req && !retire_valid) else begin
                $display("error: %0t mem_req/retire_valid in reset expected 0/0 actual %b/%b",
                         $time, mem_req, retire_valid);
                test_err++;
            end
        end
        rst_n = 1'b1;
        step_cycle();
        checks++;
        assert (mem_req) else begin
            $display("error: %0t mem_req after reset expected 1 actual %b", $time, mem_req);
            test_err++;
        end
        assert (mem_addr == RESET_PC) else begin
            $display("error: %0t mem_addr expected %h actual %h", $time, RESET_PC, mem_addr);
            test_err++;
        end
        last_ret = now;
        checking = 1'b1;
    endtask

    initial begin
        int t;
        clk       = 1'b0;
        rst_n     = 1'b0;
        mem_done  = 1'b0;
        mem_rdata = 32'd0;
        load_program();
        load_tests();
        for (t = 0; t < N_TESTS; t++) begin
            cycle_limit += 4 + test_count[t] * (4 + int'(DIV_LAT));
        end
        for (t = 0; t < N_TESTS; t++) begin
            cur_start = test_start[t];
            build_trace(test_start[t], test_count[t]);
            n_ret    = 0;
            test_err = 0;
            apply_reset();
            while (n_ret < test_count[t]) begin
                step_cycle();
            end
            errors += test_err;
            $display("test %s: %0d retires checked, %0d errors", test_name[t], n_ret, test_err);
        end
        $display("summary: %0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* rv_fetch.f */
verilog/rv_isa_pkg.sv
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/inst_queue.sv
verilog/inst_decode.sv
verilog/fetch_top.sv
tests/fetch_chk.sv
tests/fetch_tb.sv

/* Makefile */
TOOL  := verilator
FLAGS := --binary --timing --assert
TOP   := fetch_tb
FLIST := rv_fetch.f
LOG   := sim.log
BIN   := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

# pass only when the log holds the pass line
run: build
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)
